/* arb_top.f */
+incdir+rtl
rtl/arb_pkg.sv
rtl/pn_seq_gen.sv
rtl/scheme_arbiter.sv
rtl/grant_mux.sv
rtl/arb_top.sv
tests/tb_arb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build tb_arb_top with Verilator, run it, and scan the log for failures
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_arb_top \
  -f arb_top.f -o sim_arb_top > build.log 2>&1 &&
./obj_dir/sim_arb_top > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log &&
{ echo "Simulation FAILED"; exit 1; } ||
{ echo "Simulation passed"; exit 0; }

/* tests/tb_arb_top.sv */
// Testbench for the arbitration subsystem
// Clock, reset, random stimulus, reference model and watchdog
// Concurrent assertions compare gnt and xfer with the model
`timescale 1ns/1ps
`default_nettype none

`include "arb_params.svh"

module tb_arb_top;

  import arb_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int SEED         = 4259;
  localparam int RESET_CYCLES = 4;
  localparam int QUIET_CYCLES = 3;
  localparam int RR_HOLD      = 8;
  localparam int RR_RAND      = 60;
  localparam int FIXED_PER    = 40;   // Per fixed scheme
  localparam int RAND_HOLD    = 7;    // One full LFSR period
  localparam int RAND_RAND    = 60;
  localparam int UNUSED_N     = 24;
  localparam int MIX_N        = 120;
  localparam int DRAIN_CYCLES = 3;
  localparam int N_TESTS      = 6;
  localparam int TOTAL_CYCLES = RESET_CYCLES + QUIET_CYCLES + RR_HOLD + RR_RAND
                              + 4 * FIXED_PER + RAND_HOLD + RAND_RAND + UNUSED_N
                              + MIX_N + N_TESTS * (DRAIN_CYCLES + 1);
  localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 100;

  logic                          clk;
  logic                          rst_n;
  logic [`ARB_NREQ-1:0]          req;
  arb_scheme_e                   arb_scheme;
  req_payload_t [`ARB_NREQ-1:0]  payload;
  logic [`ARB_NREQ-1:0]          gnt;
  xfer_t                         xfer;

  // Reference model state
  logic                  ms1;
  logic                  ms2;
  logic                  ms3;
  int                    m_last;
  logic [`ARB_NREQ-1:0]  exp_gnt;
  xfer_t                 exp_xfer;

  string test_name;
  int    err_count;
  int    err_at_start;
  int    tests_run;
  int    tests_failed;
  int    seed_probe;

  arb_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .arb_scheme (arb_scheme),
    .payload    (payload),
    .gnt        (gnt),
    .xfer       (xfer)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic bit has_req(input logic [`ARB_NREQ-1:0] r, input int i);
    return r[i[1:0]];
  endfunction

  // Top requester first, then the rest counting up from 0
  function automatic int fixed_winner(input logic [`ARB_NREQ-1:0] r, input int top);
    if (has_req(r, top)) return top;
    for (int i = 0; i < `ARB_NREQ; i++) begin
      if (has_req(r, i)) return i;
    end
    return -1;
  endfunction

  function automatic int rr_winner(input logic [`ARB_NREQ-1:0] r, input int last);
    int c;
    for (int k = 1; k <= `ARB_NREQ; k++) begin
      c = (last + k) % `ARB_NREQ;  // Wraps past requester 3
      if (has_req(r, c)) return c;
    end
    return -1;
  endfunction

  function automatic int predict_winner(input logic [`ARB_NREQ-1:0] r,
                                        input logic [2:0] code, input int head,
                                        input int last);
    case (code)
      3'd0, 3'd1, 3'd2, 3'd3: return fixed_winner(r, int'(code));
      3'd4:                   return rr_winner(r, last);
      3'd5:                   return fixed_winner(r, head);
      default:                return -1;  // Spare codes
    endcase
  endfunction

  function automatic logic [1:0] onehot_index(input logic [`ARB_NREQ-1:0] oh);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 0; i < `ARB_NREQ; i++) begin
      if (has_req(oh, i)) idx = i[1:0];
    end
    return idx;
  endfunction

  always @(posedge clk or negedge rst_n) begin : ref_model
    int w;
    if (!rst_n) begin
      ms1      <= 1'b1;
      ms2      <= 1'b0;
      ms3      <= 1'b0;
      m_last   <= 0;
      exp_gnt  <= '0;
      exp_xfer <= '0;
    end else begin
      w = predict_winner(req, arb_scheme, int'({ms3, ms2}), m_last);
      exp_gnt <= (w >= 0) ? (4'b0001 << w) : 4'b0000;
      if (w >= 0) m_last <= w;  // Idle cycles keep the pointer
      ms1 <= ms1 ^ ms3;
      ms2 <= ms1;
      ms3 <= ms2;
      // exp_gnt still holds the grant the DUT shows now
      exp_xfer.valid <= (exp_gnt != '0);
      if (exp_gnt != '0) begin
        exp_xfer.src  <= onehot_index(exp_gnt);
        exp_xfer.data <= payload[onehot_index(exp_gnt)];
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (gnt == '0 && !xfer.valid))
    else begin
      err_count++;
      $display("CHECK FAILED %s reset gnt/valid expected 0000/0 actual %b/%b",
               test_name, $sampled(gnt), $sampled(xfer.valid));
    end

  a_gnt_match: assert property (@(posedge clk) disable iff (!rst_n) gnt == exp_gnt)
    else begin
      err_count++;
      $display("CHECK FAILED %s gnt expected %b actual %b",
               test_name, $sampled(exp_gnt), $sampled(gnt));
    end

  a_xfer_valid: assert property (@(posedge clk) disable iff (!rst_n)
    xfer.valid == exp_xfer.valid)
    else begin
      err_count++;
      $display("CHECK FAILED %s xfer.valid expected %b actual %b",
               test_name, $sampled(exp_xfer.valid), $sampled(xfer.valid));
    end

  a_xfer_record: assert property (@(posedge clk) disable iff (!rst_n)
    exp_xfer.valid |-> (xfer.src == exp_xfer.src && xfer.data == exp_xfer.data))
    else begin
      err_count++;
      $display("CHECK FAILED %s xfer src/data expected %0d/%h actual %0d/%h",
               test_name, $sampled(exp_xfer.src), $sampled(exp_xfer.data),
               $sampled(xfer.src), $sampled(xfer.data));
    end

  // New payload only while a requester is idle and ungranted
  task automatic drive(input logic [`ARB_NREQ-1:0] r, input logic [2:0] code);
    @(negedge clk);
    for (int i = 0; i < `ARB_NREQ; i++) begin
      if (!req[i[1:0]] && !gnt[i[1:0]]) payload[i[1:0]] = 16'($urandom);
    end
    req        = r;
    arb_scheme = arb_scheme_e'(code);
  endtask

  function automatic logic [`ARB_NREQ-1:0] rand_req(input int idle_pct);
    if (($urandom % 100) < idle_pct) return '0;
    return 4'($urandom % 15) + 4'd1;
  endfunction

  task automatic random_cycles(input int n, input logic [2:0] code, input int idle_pct);
    repeat (n) drive(rand_req(idle_pct), code);
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    err_at_start = err_count;
  endtask

  task automatic end_test();
    int errs;
    @(negedge clk);
    req = '0;
    repeat (DRAIN_CYCLES) @(posedge clk);  // Let in-flight transfers land
    errs = err_count - err_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("test %-16s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %-16s failed with %0d errors", test_name, errs);
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [2:0] code;
    seed_probe   = $urandom(SEED);
    rst_n        = 1'b0;
    req          = 4'b1111;  // All requesting while reset holds
    arb_scheme   = scheme_p0;
    err_count    = 0;
    err_at_start = 0;
    tests_run    = 0;
    tests_failed = 0;
    code         = 3'd0;
    for (int i = 0; i < `ARB_NREQ; i++) payload[i[1:0]] = 16'($urandom);

    begin_test("reset_quiet");
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (QUIET_CYCLES) drive(4'b0000, 3'd4);
    end_test();

    begin_test("round_robin");  // Pointer still 0 here
    repeat (RR_HOLD) drive(4'b1111, 3'd4);
    random_cycles(RR_RAND, 3'd4, 25);
    end_test();

    begin_test("fixed_priority");
    for (int s = 0; s < 4; s++) random_cycles(FIXED_PER, 3'(s), 15);
    end_test();

    begin_test("pseudo_random");
    repeat (RAND_HOLD) drive(4'b1111, 3'd5);
    random_cycles(RAND_RAND, 3'd5, 15);
    end_test();

    begin_test("unused_codes");
    for (int n = 0; n < UNUSED_N; n++) drive(rand_req(0), 3'd6 + 3'(n % 2));
    end_test();

    begin_test("transfer_mix");
    for (int n = 0; n < MIX_N; n++) begin
      code = 3'((int'(code) + 1 + $urandom % 7) % 8);  // Always a different code
      drive(rand_req(5), code);
    end
    end_test();

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/arb_top.sv */
// Arbitration subsystem top level
// Scheme arbiter feeding the transfer stage
`timescale 1ns/1ps
`default_nettype none

`include "arb_params.svh"

module arb_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`ARB_NREQ-1:0]                  req,
  input  arb_pkg::arb_scheme_e                  arb_scheme,
  input  arb_pkg::req_payload_t [`ARB_NREQ-1:0] payload,
  output logic [`ARB_NREQ-1:0]                  gnt,
  output arb_pkg::xfer_t                        xfer
);

  // gnt one cycle after req, xfer one cycle after gnt
  arb_pkg::grant_t grant;

  scheme_arbiter u_scheme_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .arb_scheme (arb_scheme),
    .grant      (grant)
  );

  grant_mux u_grant_mux (
    .clk     (clk),
    .rst_n   (rst_n),
    .grant   (grant),
    .payload (payload),
    .xfer    (xfer)
  );

  assign gnt = grant.onehot;

  // End to end, a transfer source had its request up two edges back
  a_xfer_src_requested: assert property (@(posedge clk) disable iff (!rst_n)
    xfer.valid |-> (|($past(req, 2) & (`ARB_NREQ'(1) << xfer.src))));

  // Transfer source matches the grant seen one cycle earlier
  a_xfer_src_is_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    xfer.valid |-> ($past(gnt) == (`ARB_NREQ'(1) << xfer.src)));

endmodule

`default_nettype wire

/* rtl/grant_mux.sv */
// Transfer stage behind the arbiter
// Registers the winner's payload with its source index
`timescale 1ns/1ps
`default_nettype none

`include "arb_params.svh"

module grant_mux (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  arb_pkg::grant_t                       grant,
  input  arb_pkg::req_payload_t [`ARB_NREQ-1:0] payload,
  output arb_pkg::xfer_t                        xfer
);

  import arb_pkg::*;

  req_payload_t          sel_data;
  logic                  valid_q;
  logic [ARB_IDX_W-1:0]  src_q;
  req_payload_t          data_q;

  assign sel_data = payload[grant.idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= grant.valid;
    end
  end

  // Record holds its last contents when nobody is granted
  always_ff @(posedge clk) begin
    if (grant.valid) begin
      src_q  <= grant.idx;
      data_q <= sel_data;
    end
  end

  assign xfer = '{valid: valid_q, src: src_q, data: data_q};

  a_xfer_follows_grant: assert property (@(posedge clk) disable iff (!rst_n)
    xfer.valid |-> $past(grant.valid));

endmodule

`default_nettype wire

/* rtl/scheme_arbiter.sv */
// Four-way arbiter with six selectable schemes
// Fixed priority p0..p3, round robin, LFSR head
// Registered one-hot grant with index and valid
`timescale 1ns/1ps
`default_nettype none

`include "arb_params.svh"

module scheme_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`ARB_NREQ-1:0]  req,
  input  arb_pkg::arb_scheme_e  arb_scheme,
  output arb_pkg::grant_t       grant
);

  import arb_pkg::*;

  logic [ARB_IDX_W-1:0] rand_head;
  logic [ARB_IDX_W-1:0] fixed_head;
  logic [ARB_IDX_W-1:0] last_win;   // Round robin pointer

  grant_t cand_fixed;
  grant_t cand_rr;
  grant_t cand_rand;
  grant_t next_grant;

  // Head requester first, then the others in ascending order
  function automatic grant_t pick_fixed(input logic [`ARB_NREQ-1:0] r,
                                        input logic [ARB_IDX_W-1:0] head);
    grant_t g;
    g = '0;
    if (r[head]) begin
      g.onehot[head] = 1'b1;
      g.idx          = head;
      g.valid        = 1'b1;
    end else begin
      for (int i = 0; i < `ARB_NREQ; i++) begin
        if (!g.valid && r[i]) begin
          g.onehot[i] = 1'b1;
          g.idx       = ARB_IDX_W'(i);
          g.valid     = 1'b1;
        end
      end
    end
    return g;
  endfunction

  // Search starts one past the last winner and wraps
  function automatic grant_t pick_rr(input logic [`ARB_NREQ-1:0] r,
                                     input logic [ARB_IDX_W-1:0] last);
    grant_t               g;
    logic [ARB_IDX_W-1:0] j;
    g = '0;
    for (int k = 1; k <= `ARB_NREQ; k++) begin
      j = last + ARB_IDX_W'(k);  // Index wraps mod 4
      if (!g.valid && r[j]) begin
        g.onehot[j] = 1'b1;
        g.idx       = j;
        g.valid     = 1'b1;
      end
    end
    return g;
  endfunction

  pn_seq_gen u_pn_seq_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .rand_head (rand_head)
  );

  // Low code bits name the top requester for p0..p3
  assign fixed_head = ARB_IDX_W'(arb_scheme);

  assign cand_fixed = pick_fixed(req, fixed_head);
  assign cand_rand  = pick_fixed(req, rand_head);
  assign cand_rr    = pick_rr(req, last_win);

  always_comb begin
    case (arb_scheme)
      scheme_p0,
      scheme_p1,
      scheme_p2,
      scheme_p3:   next_grant = cand_fixed;
      scheme_rr:   next_grant = cand_rr;
      scheme_rand: next_grant = cand_rand;
      default:     next_grant = '0;  // Spare codes grant nothing
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant    <= '0;
      last_win <= '0;
    end else begin
      grant <= next_grant;
      // Pointer moves on any grant, holds through idle
      if (next_grant.valid) begin
        last_win <= next_grant.idx;
      end
    end
  end

  // At most one winner per cycle
  a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant.onehot));

  // Every grant bit was requested on the sampling edge
  a_gnt_had_req: assert property (@(posedge clk) disable iff (!rst_n)
    (|grant.onehot) |-> ((grant.onehot & ~$past(req)) == '0));

  a_spare_code_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(arb_scheme) > scheme_rand) |-> (grant.onehot == '0));

  // Under p0 no lower-numbered request may be skipped
  a_p0_lowest_first: assert property (@(posedge clk) disable iff (!rst_n)
    (grant.valid && $past(arb_scheme) == scheme_p0)
      |-> (($past(req) & (grant.onehot - 1'b1)) == '0));

endmodule

`default_nettype wire

/* rtl/pn_seq_gen.sv */
// 3-bit Fibonacci LFSR, period 7
// Two oldest stages give the random head index
`timescale 1ns/1ps
`default_nettype none

module pn_seq_gen (
  input  logic       clk,
  input  logic       rst_n,
  output logic [1:0] rand_head
);

  logic s1;
  logic s2;
  logic s3;
  logic fb;

  assign fb = s1 ^ s3;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;  // Nonzero seed
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= fb;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_head = {s3, s2};

  // Zero state would lock the sequence
  a_state_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    {s1, s2, s3} != 3'b000);

endmodule

`default_nettype wire

/* rtl/arb_pkg.sv */
// Shared types for the arbitration subsystem
// Scheme enum, grant word, payload word, transfer record
`default_nettype none

`include "arb_params.svh"

package arb_pkg;

  localparam int unsigned ARB_IDX_W = $clog2(`ARB_NREQ);

  typedef enum logic [`ARB_SCHEME_W-1:0] {
    scheme_p0   = 3'd0,  // Fixed, req 0 on top
    scheme_p1   = 3'd1,
    scheme_p2   = 3'd2,
    scheme_p3   = 3'd3,
    scheme_rr   = 3'd4,  // Round robin
    scheme_rand = 3'd5   // LFSR picks the head
  } arb_scheme_e;

  typedef logic [`ARB_DATA_W-1:0] req_payload_t;

  typedef struct packed {
    logic [`ARB_NREQ-1:0]  onehot;
    logic [ARB_IDX_W-1:0]  idx;
    logic                  valid;
  } grant_t;

  typedef struct packed {
    logic                  valid;
    logic [ARB_IDX_W-1:0]  src;
    req_payload_t          data;
  } xfer_t;

endpackage

`default_nettype wire

/* rtl/arb_params.svh */
// Global sizes for the four-way arbitration subsystem
// Requester count, scheme code width, payload width
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// Scheme tables assume exactly four requesters
`define ARB_NREQ 4

// Six schemes used, codes 6 and 7 spare
`define ARB_SCHEME_W 3

`define ARB_DATA_W 16

`endif
